//--- Bender.yml
package:
  name: fetch_stage

sources:
  # rtl
  - include_dirs:
      - hw
    files:
      - hw/fetch_pkg.sv
      - hw/icache_array.sv
      - hw/icache_refill.sv
      - hw/inst_predecode.sv
      - hw/fetch_ctrl.sv
      - hw/fetch_top.sv
  # tb
  - target: test
    include_dirs:
      - hw
    files:
      - tb/fetch_assertions.sv
      - tb/fetch_tb.sv

//--- hw/fetch_config.svh
`ifndef FETCH_CONFIG_SVH
`define FETCH_CONFIG_SVH

// First instruction fetched after reset
`define FETCH_RESET_PC 32'h8000_0000

`define ICACHE_SET_BITS  2  // 4 sets
`define ICACHE_WORD_BITS 1  // Two words per line

// RV32I major opcodes seen by the predecoder
`define OPC_JAL    7'b1101111
`define OPC_JALR   7'b1100111
`define OPC_BRANCH 7'b1100011
`define OPC_SYSTEM 7'b1110011
`define OPC_LOAD   7'b0000011
`define OPC_STORE  7'b0100011

// fence.i with rd, rs1 and imm all zero
`define INST_FENCE_I 32'h0000_100f

`endif

//--- hw/fetch_ctrl.sv
`timescale 1ns/10ps
`include "fetch_config.svh"

module fetch_ctrl (
  input  logic                    clk,
  input  logic                    rst,
  output fetch_pkg::fetch_addr_u  pc_o,
  input  logic                    hit_i,
  input  logic [31:0]             inst_i,
  input  fetch_pkg::inst_class_t  class_i,
  input  logic                    refill_busy_i,
  output logic                    miss_req_o,
  output logic                    flush_all_o,
  output fetch_pkg::fetch_pkt_t   fetch_o,
  output logic                    fetch_valid_o,
  input  logic                    fetch_ready_i,
  input  fetch_pkg::resolve_t     resolve_i,
  output fetch_pkg::spec_status_t spec_o
);

  fetch_pkg::fetch_addr_u pc_q;
  logic                   hazard_q;
  logic [31:0]            btb_q;
  logic                   btb_valid_q;
  logic                   spec_q;
  logic                   good_q;
  logic                   bad_q;
  logic [31:0]            spec_target_q;
  logic [31:0]            spec_fall_q;
  logic [31:0]            redir_pc_q;
  logic                   held_q;
  logic                   held_spec_q;
  logic                   issue;
  logic                   lsu_held;
  logic                   open_spec;
  logic                   btb_we;
  logic [31:0]            pc_plus4;
  logic [31:0]            fall_pc;

  assign pc_plus4 = pc_q.raw + 32'd4;
  assign lsu_held = spec_q && (class_i.is_load || class_i.is_store);

  assign fetch_valid_o = hit_i && !hazard_q && !bad_q && !lsu_held;
  assign issue         = fetch_valid_o && fetch_ready_i;
  assign open_spec     = issue && class_i.is_branch && btb_valid_q && !spec_q;
  assign miss_req_o    = !hit_i && !refill_busy_i && !bad_q;
  assign flush_all_o   = issue && class_i.is_fence;

  // Resolved target differs from the fall-through of the resolved instruction
  assign fall_pc = spec_q ? spec_fall_q : pc_plus4;
  assign btb_we  = resolve_i.valid && (resolve_i.next_pc != fall_pc);

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q.raw    <= `FETCH_RESET_PC;
      hazard_q    <= 1'b0;
      btb_valid_q <= 1'b0;
      spec_q      <= 1'b0;
      good_q      <= 1'b0;
      bad_q       <= 1'b0;
      held_q      <= 1'b0;
    end else begin
      good_q <= 1'b0;
      held_q <= fetch_valid_o && !fetch_ready_i;
      if (btb_we) btb_valid_q <= 1'b1;
      if (issue) begin
        if (open_spec) begin
          pc_q.raw <= btb_q;
          spec_q   <= 1'b1;
        end else if (class_i.is_branch || class_i.is_load) begin
          hazard_q <= 1'b1;  // Wait for the back end
        end else begin
          pc_q.raw <= pc_plus4;
        end
      end
      if (resolve_i.valid) begin
        if (spec_q) begin
          spec_q <= 1'b0;
          good_q <= (resolve_i.next_pc == spec_target_q);
          bad_q  <= (resolve_i.next_pc != spec_target_q);
        end else if (hazard_q) begin
          hazard_q <= 1'b0;  // No refill can be running while stalled on a hit
          pc_q.raw <= resolve_i.next_pc;
        end
      end
      if (bad_q && !refill_busy_i) begin
        bad_q    <= 1'b0;
        hazard_q <= 1'b0;
        pc_q.raw <= redir_pc_q;
      end
    end
  end

  always_ff @(posedge clk) begin
    held_spec_q <= fetch_o.spec;
    if (btb_we) btb_q <= resolve_i.next_pc;
    if (open_spec) begin
      spec_target_q <= btb_q;
      spec_fall_q   <= pc_plus4;
    end
    if (resolve_i.valid && spec_q) redir_pc_q <= resolve_i.next_pc;
  end

  assign pc_o = pc_q;

  // A stalled packet keeps its spec bit even if the speculation closes good
  assign fetch_o.pc   = pc_q.raw;
  assign fetch_o.inst = inst_i;
  assign fetch_o.spec = held_q ? held_spec_q : spec_q;

  assign spec_o.active = spec_q;
  assign spec_o.good   = good_q;
  assign spec_o.bad    = bad_q;

endmodule

//--- hw/fetch_pkg.sv
`include "fetch_config.svh"

package fetch_pkg;

  localparam int TAG_W = 32 - `ICACHE_SET_BITS - `ICACHE_WORD_BITS - 2;

  typedef struct packed {
    logic [TAG_W-1:0]             tag;
    logic [`ICACHE_SET_BITS-1:0]  index;
    logic [`ICACHE_WORD_BITS-1:0] word;
    logic [1:0]                   byte_off;
  } fetch_fields_t;

  // Same address seen as a plain word or split for the cache
  typedef union packed {
    logic [31:0]   raw;
    fetch_fields_t f;
  } fetch_addr_u;

  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] inst;
    logic        spec;  // Issued while a speculation is open
  } fetch_pkt_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] next_pc;
  } resolve_t;

  typedef struct packed {
    logic active;
    logic good;
    logic bad;
  } spec_status_t;

  typedef struct packed {
    logic [31:0] addr;
    logic [2:0]  prot;
  } axi_ar_t;

  typedef struct packed {
    logic [31:0] data;
    logic [1:0]  resp;
  } axi_r_t;

  typedef struct packed {
    logic is_branch;
    logic is_load;
    logic is_store;
    logic is_fence;
  } inst_class_t;

  typedef struct packed {
    logic                         we;
    fetch_addr_u                  addr;
    logic [`ICACHE_WORD_BITS-1:0] word;
    logic [31:0]                  data;
    logic                         last;  // Second word of the line
  } line_fill_t;

endpackage

//--- hw/fetch_top.sv
`timescale 1ns/10ps

module fetch_top (
  input  logic                    clk,
  input  logic                    rst,
  output fetch_pkg::axi_ar_t      m_ar_o,
  output logic                    m_arvalid_o,
  input  logic                    m_arready_i,
  input  fetch_pkg::axi_r_t       m_r_i,
  input  logic                    m_rvalid_i,
  output logic                    m_rready_o,
  output fetch_pkg::fetch_pkt_t   fetch_o,
  output logic                    fetch_valid_o,
  input  logic                    fetch_ready_i,
  input  fetch_pkg::resolve_t     resolve_i,
  output fetch_pkg::spec_status_t spec_o
);

  fetch_pkg::fetch_addr_u pc;
  fetch_pkg::inst_class_t inst_class;
  fetch_pkg::line_fill_t  fill;
  logic                   hit;
  logic [31:0]            inst;
  logic                   refill_busy;
  logic                   miss_req;
  logic                   flush_all;

  fetch_ctrl u_ctrl (
    .clk           (clk),
    .rst           (rst),
    .pc_o          (pc),
    .hit_i         (hit),
    .inst_i        (inst),
    .class_i       (inst_class),
    .refill_busy_i (refill_busy),
    .miss_req_o    (miss_req),
    .flush_all_o   (flush_all),
    .fetch_o       (fetch_o),
    .fetch_valid_o (fetch_valid_o),
    .fetch_ready_i (fetch_ready_i),
    .resolve_i     (resolve_i),
    .spec_o        (spec_o)
  );

  icache_array u_array (
    .clk         (clk),
    .rst         (rst),
    .addr_i      (pc),
    .fill_i      (fill),
    .flush_all_i (flush_all),
    .hit_o       (hit),
    .inst_o      (inst)
  );

  icache_refill u_refill (
    .clk         (clk),
    .rst         (rst),
    .miss_req_i  (miss_req),
    .miss_addr_i (pc),
    .fill_o      (fill),
    .busy_o      (refill_busy),
    .m_ar_o      (m_ar_o),
    .m_arvalid_o (m_arvalid_o),
    .m_arready_i (m_arready_i),
    .m_r_i       (m_r_i),
    .m_rvalid_i  (m_rvalid_i),
    .m_rready_o  (m_rready_o)
  );

  inst_predecode u_predecode (
    .inst_i  (inst),
    .class_o (inst_class)
  );

endmodule

//--- hw/icache_array.sv
`timescale 1ns/10ps
`include "fetch_config.svh"

module icache_array (
  input  logic                   clk,
  input  logic                   rst,
  input  fetch_pkg::fetch_addr_u addr_i,
  input  fetch_pkg::line_fill_t  fill_i,
  input  logic                   flush_all_i,
  output logic                   hit_o,
  output logic [31:0]            inst_o
);

  localparam int SETS  = 1 << `ICACHE_SET_BITS;
  localparam int WORDS = 1 << `ICACHE_WORD_BITS;

  logic [31:0]                 data_q [SETS][WORDS];
  logic [fetch_pkg::TAG_W-1:0] tag_q  [SETS];
  logic [SETS-1:0]             valid_q;
  logic                        fwd;

  always_ff @(posedge clk) begin
    if (fill_i.we) begin
      data_q[fill_i.addr.f.index][fill_i.word] <= fill_i.data;
      tag_q[fill_i.addr.f.index] <= fill_i.addr.f.tag;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
    end else if (flush_all_i) begin
      valid_q <= '0;
    end else if (fill_i.we) begin
      // First word drops the old line, last word publishes the new one
      valid_q[fill_i.addr.f.index] <= fill_i.last;
    end
  end

  assign hit_o = valid_q[addr_i.f.index] && (tag_q[addr_i.f.index] == addr_i.f.tag);

  // Word on its way into the array that the PC is looking at right now
  assign fwd = fill_i.we &&
               (fill_i.addr.f.tag == addr_i.f.tag) &&
               (fill_i.addr.f.index == addr_i.f.index) &&
               (fill_i.word == addr_i.f.word);

  always_comb begin
    if (fwd) begin
      inst_o = fill_i.data;
    end else begin
      inst_o = data_q[addr_i.f.index][addr_i.f.word];
    end
  end

endmodule

//--- hw/icache_refill.sv
`timescale 1ns/10ps

module icache_refill (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   miss_req_i,
  input  fetch_pkg::fetch_addr_u miss_addr_i,
  output fetch_pkg::line_fill_t  fill_o,
  output logic                   busy_o,
  output fetch_pkg::axi_ar_t     m_ar_o,
  output logic                   m_arvalid_o,
  input  logic                   m_arready_i,
  input  fetch_pkg::axi_r_t      m_r_i,
  input  logic                   m_rvalid_i,
  output logic                   m_rready_o
);

  typedef enum logic [2:0] {
    S_IDLE,
    S_AR0,
    S_R0,
    S_AR1,
    S_R1
  } state_e;

  state_e                 state_q;
  fetch_pkg::fetch_addr_u line_q;
  fetch_pkg::fetch_addr_u cur_addr;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= S_IDLE;
    end else begin
      case (state_q)
        S_IDLE: if (miss_req_i) state_q <= S_AR0;
        S_AR0:  if (m_arready_i) state_q <= S_R0;
        S_R0:   if (m_rvalid_i) state_q <= S_AR1;
        S_AR1:  if (m_arready_i) state_q <= S_R1;
        S_R1:   if (m_rvalid_i) state_q <= S_IDLE;
        default: state_q <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == S_IDLE && miss_req_i) begin
      line_q <= miss_addr_i;  // Held for both reads of the line
    end
  end

  // Word 0 sits at the line address, word 1 four bytes above
  always_comb begin
    cur_addr            = line_q;
    cur_addr.f.word     = (state_q == S_AR1 || state_q == S_R1) ? 1'b1 : 1'b0;
    cur_addr.f.byte_off = 2'b00;
  end

  assign m_ar_o.addr = cur_addr.raw;
  assign m_ar_o.prot = 3'b100;  // Unprivileged, secure, instruction
  assign m_arvalid_o = (state_q == S_AR0) || (state_q == S_AR1);
  assign m_rready_o  = (state_q == S_R0) || (state_q == S_R1);
  assign busy_o      = (state_q != S_IDLE);

  // Any resp value counts as data
  assign fill_o.we   = m_rvalid_i && m_rready_o;
  assign fill_o.addr = cur_addr;
  assign fill_o.word = cur_addr.f.word;
  assign fill_o.data = m_r_i.data;
  assign fill_o.last = (state_q == S_R1);

endmodule

//--- hw/inst_predecode.sv
`timescale 1ns/10ps
`include "fetch_config.svh"

module inst_predecode (
  input  logic [31:0]            inst_i,
  output fetch_pkg::inst_class_t class_o
);

  logic [6:0] opcode;

  assign opcode = inst_i[6:0];

  always_comb begin
    // Anything that may leave the sequential path
    class_o.is_branch = (opcode == `OPC_JAL) ||
                        (opcode == `OPC_JALR) ||
                        (opcode == `OPC_BRANCH) ||
                        (opcode == `OPC_SYSTEM);
    class_o.is_load   = (opcode == `OPC_LOAD);
    class_o.is_store  = (opcode == `OPC_STORE);
    class_o.is_fence  = (inst_i == `INST_FENCE_I);
  end

endmodule

//--- tb/fetch_assertions.sv
`timescale 1ns/10ps
`include "fetch_config.svh"

module fetch_assertions (
  input logic                    clk,
  input logic                    rst,
  input fetch_pkg::axi_ar_t      m_ar_o,
  input logic                    m_arvalid_o,
  input logic                    m_arready_i,
  input fetch_pkg::axi_r_t       m_r_i,
  input logic                    m_rvalid_i,
  input logic                    m_rready_o,
  input fetch_pkg::fetch_pkt_t   fetch_o,
  input logic                    fetch_valid_o,
  input logic                    fetch_ready_i,
  input fetch_pkg::resolve_t     resolve_i,
  input fetch_pkg::spec_status_t spec_o
);

  int          fail_cnt = 0;
  logic [31:0] shadow [32];  // Words returned by the bus, by word address
  logic [31:0] rd_addr_q;
  logic [31:0] line_q;
  logic [31:0] last_pc_q;
  logic [31:0] pend_pc_q;
  logic [31:0] exp_pc_q;
  logic [31:0] btb_tgt_q;
  logic [31:0] tgt_q;
  logic        odd_q;
  logic        r_pend_q;
  logic        plain_q;
  logic        wait_q;
  logic        exp_v_q;
  logic        btb_known_q;
  logic        flushed_q;
  logic        open_q;
  logic        issue;
  logic        is_br;
  logic        is_ld;
  logic        is_st;
  logic        ar_hs;
  logic        r_hs;
  logic        bad_res;

  assign issue   = fetch_valid_o && fetch_ready_i;
  assign is_br   = fetch_o.inst[6:0] inside {`OPC_JAL, `OPC_JALR, `OPC_BRANCH, `OPC_SYSTEM};
  assign is_ld   = fetch_o.inst[6:0] == `OPC_LOAD;
  assign is_st   = fetch_o.inst[6:0] == `OPC_STORE;
  assign ar_hs   = m_arvalid_o && m_arready_i;
  assign r_hs    = m_rvalid_i && m_rready_o;
  assign bad_res = resolve_i.valid && open_q && resolve_i.next_pc != tgt_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      {odd_q, r_pend_q, plain_q, wait_q, exp_v_q, btb_known_q, flushed_q, open_q} <= '0;
    end else begin
      if (ar_hs) begin
        odd_q     <= !odd_q;
        r_pend_q  <= 1'b1;
        rd_addr_q <= m_ar_o.addr;
        flushed_q <= 1'b0;
        if (!odd_q) line_q <= m_ar_o.addr;
      end
      if (r_hs) begin
        r_pend_q                <= 1'b0;
        shadow[rd_addr_q[6:2]] <= m_r_i.data;
      end
      if (issue) begin
        plain_q   <= !(is_br || is_ld);
        last_pc_q <= fetch_o.pc;
        exp_v_q   <= 1'b0;
        if (fetch_o.inst == `INST_FENCE_I) flushed_q <= 1'b1;
        if (is_br || is_ld) pend_pc_q <= fetch_o.pc;
        if (is_ld || (is_br && !btb_known_q)) wait_q <= 1'b1;
        if (is_br && btb_known_q && !open_q) begin
          open_q   <= 1'b1;  // Guessed path starts at the BTB target
          tgt_q    <= btb_tgt_q;
          exp_v_q  <= 1'b1;
          exp_pc_q <= btb_tgt_q;
        end
      end
      if (resolve_i.valid) begin
        if (open_q) open_q <= 1'b0;
        if (resolve_i.next_pc != pend_pc_q + 32'd4) begin
          btb_known_q <= 1'b1;
          btb_tgt_q   <= resolve_i.next_pc;
        end
        if (wait_q || bad_res) begin
          wait_q   <= 1'b0;
          exp_v_q  <= 1'b1;
          exp_pc_q <= resolve_i.next_pc;
        end
        if (bad_res) plain_q <= 1'b0;
      end
    end
  end

  a_inst: assert property (@(posedge clk) disable iff (rst)
    fetch_valid_o |-> fetch_o.inst == shadow[fetch_o.pc[6:2]])
    else begin
      fail_cnt++;
      $error("mismatch at %0t: inst %h at pc %h", $time, fetch_o.inst, fetch_o.pc);
    end
  a_seq: assert property (@(posedge clk) disable iff (rst)
    issue && plain_q |-> fetch_o.pc == last_pc_q + 32'd4)
    else begin
      fail_cnt++;
      $error("mismatch at %0t: pc %h after %h", $time, fetch_o.pc, last_pc_q);
    end
  a_pair: assert property (@(posedge clk) disable iff (rst)
    ar_hs |-> m_ar_o.addr[2] == odd_q && (!odd_q || m_ar_o.addr == line_q + 32'd4))
    else begin
      fail_cnt++;
      $error("mismatch at %0t: read address %h", $time, m_ar_o.addr);
    end
  a_ar_hold: assert property (@(posedge clk) disable iff (rst)
    m_arvalid_o && !m_arready_i |=> m_arvalid_o && $stable(m_ar_o))
    else begin
      fail_cnt++;
      $error("read address request changed before it was accepted");
    end
  a_one_read: assert property (@(posedge clk) disable iff (rst) m_arvalid_o |-> !r_pend_q)
    else begin
      fail_cnt++;
      $error("a second read started before the first one returned");
    end
  a_align: assert property (@(posedge clk) disable iff (rst)
    m_arvalid_o |-> m_ar_o.addr[1:0] == 2'b00)
    else begin
      fail_cnt++;
      $error("mismatch at %0t: unaligned read %h", $time, m_ar_o.addr);
    end
  a_pkt_hold: assert property (@(posedge clk) disable iff (rst)
    fetch_valid_o && !fetch_ready_i && !bad_res |=> fetch_valid_o && $stable(fetch_o))
    else begin
      fail_cnt++;
      $error("a stalled fetch packet changed or was dropped");
    end
  a_stall: assert property (@(posedge clk) disable iff (rst) wait_q |-> !fetch_valid_o)
    else begin
      fail_cnt++;
      $error("a packet was offered while waiting for the back end");
    end
  a_redirect: assert property (@(posedge clk) disable iff (rst)
    issue && exp_v_q |-> fetch_o.pc == exp_pc_q)
    else begin
      fail_cnt++;
      $error("mismatch at %0t: pc %h, expected %h", $time, fetch_o.pc, exp_pc_q);
    end
  a_active: assert property (@(posedge clk) disable iff (rst) spec_o.active == open_q)
    else begin
      fail_cnt++;
      $error("mismatch at %0t: spec active %b, expected %b", $time, spec_o.active, open_q);
    end
  a_spec_bit: assert property (@(posedge clk) disable iff (rst)
    issue && open_q |-> fetch_o.spec && !is_ld && !is_st)
    else begin
      fail_cnt++;
      $error("a speculative packet lacked its mark or was a load or store");
    end
  a_good: assert property (@(posedge clk) disable iff (rst)
    resolve_i.valid && open_q && !bad_res |=> spec_o.good ##1 !spec_o.good)
    else begin
      fail_cnt++;
      $error("a correct guess did not give a one-cycle good pulse");
    end
  a_bad: assert property (@(posedge clk) disable iff (rst) bad_res |=> spec_o.bad)
    else begin
      fail_cnt++;
      $error("a wrong guess was not reported as bad");
    end
  a_flush: assert property (@(posedge clk) disable iff (rst) flushed_q |-> !fetch_valid_o)
    else begin
      fail_cnt++;
      $error("a packet was served from the cache after the invalidate");
    end

endmodule

bind fetch_top fetch_assertions u_chk (.*);

//--- tb/fetch_tb.sv
`timescale 1ns/10ps
`include "fetch_config.svh"

module fetch_tb;

  localparam logic [31:0] LAST_PC = 32'h8000_0070;
  localparam int          MAX_CYCLES = 4000;

  logic                    clk = 1'b0;
  logic                    rst;
  fetch_pkg::axi_ar_t      m_ar_o;
  logic                    m_arvalid_o;
  logic                    m_arready_i;
  fetch_pkg::axi_r_t       m_r_i;
  logic                    m_rvalid_i;
  logic                    m_rready_o;
  fetch_pkg::fetch_pkt_t   fetch_o;
  logic                    fetch_valid_o;
  logic                    fetch_ready_i;
  fetch_pkg::resolve_t     resolve_i;
  fetch_pkg::spec_status_t spec_o;

  logic [31:0] ar_addr;
  logic        r_pend;
  int          r_delay;
  logic [31:0] res_pc;
  logic        res_pend;
  int          res_delay;
  int          beq_count;
  logic        saw_good;
  logic        saw_bad;
  logic        done;
  int          timeouts;
  int          missing;
  int          cycles;

  always #5 clk = ~clk;

  fetch_top DUT (.*);

  // Every address not listed holds an ADDI with the address bits as immediate
  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    case (addr)
      32'h8000_0008: return 32'h0011_2023;  // sw x1, 0(x2)
      32'h8000_0010: return 32'h0300_006f;  // jal x0, +48
      32'h8000_0044: return 32'h0001_2183;  // lw x3, 0(x2)
      32'h8000_004c: return 32'hfe00_0ae3;  // beq x0, x0, back to 0x40
      32'h8000_0060: return `INST_FENCE_I;
      default:       return {addr[13:2], 5'd0, 3'b000, 5'd1, 7'b0010011};
    endcase
  endfunction

  function automatic logic [31:0] real_next_pc(input logic [31:0] pc, input int beqs);
    case (pc)
      32'h8000_0010: return 32'h8000_0040;
      // Second pass leaves the loop
      32'h8000_004c: return (beqs == 0) ? 32'h8000_0040 : 32'h8000_0060;
      default:       return pc + 32'd4;
    endcase
  endfunction

  function automatic logic needs_resolve(input logic [31:0] inst);
    return (inst[6:0] == `OPC_JAL) || (inst[6:0] == `OPC_JALR) ||
           (inst[6:0] == `OPC_BRANCH) || (inst[6:0] == `OPC_SYSTEM) ||
           (inst[6:0] == `OPC_LOAD);
  endfunction

  // AXI slave, back end and progress tracking
  always @(posedge clk) begin
    m_arready_i   <= ($urandom % 3) != 0;
    fetch_ready_i <= ($urandom % 4) != 0;
    resolve_i     <= '0;
    if (m_arvalid_o && m_arready_i) begin
      ar_addr <= m_ar_o.addr;
      r_pend  <= 1'b1;
      r_delay <= $urandom % 3;
    end
    if (r_pend && !m_rvalid_i) begin
      if (r_delay == 0) begin
        m_rvalid_i <= 1'b1;
        m_r_i      <= '{data: mem_word(ar_addr), resp: 2'b00};
      end else begin
        r_delay <= r_delay - 1;
      end
    end
    if (m_rvalid_i && m_rready_o) begin
      m_rvalid_i <= 1'b0;
      r_pend     <= 1'b0;
    end
    if (fetch_valid_o && fetch_ready_i && needs_resolve(fetch_o.inst)) begin
      res_pc    <= fetch_o.pc;
      res_pend  <= 1'b1;
      res_delay <= 3;
    end else if (res_pend) begin
      if (res_delay == 0) begin
        resolve_i <= '{valid: 1'b1, next_pc: real_next_pc(res_pc, beq_count)};
        res_pend  <= 1'b0;
        if (res_pc == 32'h8000_004c) beq_count <= beq_count + 1;
      end else begin
        res_delay <= res_delay - 1;
      end
    end
    if (spec_o.good) saw_good <= 1'b1;
    if (spec_o.bad) saw_bad <= 1'b1;
    if (fetch_valid_o && fetch_ready_i && fetch_o.pc == LAST_PC) done <= 1'b1;
  end

  initial begin
    void'($urandom(32));
    rst           = 1'b1;
    m_arready_i   = 1'b0;
    m_r_i         = '0;
    m_rvalid_i    = 1'b0;
    fetch_ready_i = 1'b0;
    resolve_i     = '0;
    r_pend        = 1'b0;
    r_delay       = 0;
    res_pend      = 1'b0;
    res_delay     = 0;
    beq_count     = 0;
    saw_good      = 1'b0;
    saw_bad       = 1'b0;
    done          = 1'b0;
    timeouts      = 0;
    missing       = 0;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    cycles = 0;
    while (!done && cycles < MAX_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    if (!done) begin
      timeouts++;
      $display("timeout: the program never issued its last instruction");
    end
    if (!saw_good || !saw_bad) begin
      missing++;
      $display("the run did not see both a good and a bad speculation");
    end
    $display("errors: %0d assertion failures, %0d timeouts, %0d missed events",
             DUT.u_chk.fail_cnt, timeouts, missing);
    if (DUT.u_chk.fail_cnt + timeouts + missing == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

//--- vlog.f
+incdir+hw
hw/fetch_pkg.sv
hw/icache_array.sv
hw/icache_refill.sv
hw/inst_predecode.sv
hw/fetch_ctrl.sv
hw/fetch_top.sv
tb/fetch_assertions.sv
tb/fetch_tb.sv
